//--- src.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_decode.sv
verilog/cpu_execute.sv
verilog/cpu_result.sv
verilog/cpu_core.sv
verilog/cpu_sram.sv
verilog/cpu_top.sv
test/cpu_checker.sv
test/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f src.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Let every assertion failure through so the testbench can count it
output=$(./obj_dir/Vcpu_tb +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

//--- test/cpu_tb.sv
`include "cpu_settings.svh"

module cpu_tb import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // Every instruction of every program at 4 cycles, plus slack
    localparam int timeout_cycles = (14 + 6 + 11 + 5) * 4 + 50;
    localparam word_t ebreak_word = 32'h0010_0073;

    logic                    clock;
    logic                    arst_n;
    logic                    run;
    logic                    load_en;
    logic [`CPU_IMEM_AW-1:0] load_addr;
    word_t                   load_data;
    logic                    retire_valid;
    pc_t                     retire_pc;
    reg_idx_t                retire_rd;
    word_t                   retire_value;
    logic                    halted;

    int       errors;
    int       checks;
    int       cycles;
    int       total_errors;
    word_t    prog[$];
    pc_t      exp_pc[$];
    reg_idx_t exp_rd[$];
    word_t    exp_val[$];

    cpu_top i_dut (
        .clock        (clock),
        .arst_n       (arst_n),
        .run          (run),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_value (retire_value),
        .halted       (halted)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Watchdog, counts only cycles with the core running
    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clock);
            if (run) cycles++;
        end
        $display("Timeout: core did not halt within %0d running cycles", timeout_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // RV32I encoders
    //////////////////////////////////////////////////

    function automatic word_t lui_op(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t imm_op(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                     logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t reg_op(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t lw_op(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t sw_op(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch_op(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                        logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t jal_op(reg_idx_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    //////////////////////////////////////////////////
    // Program building and checking
    //////////////////////////////////////////////////

    task automatic check_value(string name, word_t got, word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic expect_retire(pc_t pc, reg_idx_t rd, word_t value);
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_val.push_back(value);
    endtask

    // Instruction that retires at its own address
    task automatic step(word_t instr, reg_idx_t rd, word_t value);
        expect_retire(pc_t'(prog.size() * 4), rd, value);
        prog.push_back(instr);
    endtask

    task automatic check_retire();
        assert (exp_pc.size() > 0) else begin
            errors++;
            $display("Unexpected retire at pc %h after the last expected one", retire_pc);
        end
        if (exp_pc.size() > 0) begin
            check_value("retire_pc", retire_pc, exp_pc.pop_front());
            check_value("retire_rd", word_t'(retire_rd), word_t'(exp_rd.pop_front()));
            check_value("retire_value", retire_value, exp_val.pop_front());
        end
    endtask

    task automatic run_program(string name);
        $display("Running %s program", name);
        foreach (prog[i]) begin
            @(posedge clock);
            #1;
            load_en   = 1'b1;
            load_addr = `CPU_IMEM_AW'(i);
            load_data = prog[i];
        end
        @(posedge clock);
        #1;
        load_en = 1'b0;
        run     = 1'b1;
        while (!halted) begin
            @(negedge clock);
            if (retire_valid) check_retire();
        end
        // Nothing may retire once halted
        repeat (3) begin
            @(negedge clock);
            check_value("retire_valid", word_t'(retire_valid), '0);
        end
        assert (exp_pc.size() == 0) else begin
            errors++;
            $display("%s program halted with %0d retires still missing", name, exp_pc.size());
        end
        @(posedge clock);
        #1;
        run = 1'b0;
        @(posedge clock);
        #1;
        prog.delete();
        exp_pc.delete();
        exp_rd.delete();
        exp_val.delete();
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic reset_state_test();
        @(negedge clock);
        check_value("retire_valid", word_t'(retire_valid), '0);
        check_value("halted", word_t'(halted), '0);
    endtask

    task automatic alu_test();
        word_t a, b, c, d, e;
        a = 32'h12345 << 12;
        b = 32'd100;
        c = 32'd0 - 32'd7;
        d = b | 32'h0000_00F0;
        e = d ^ 32'hFFFF_FFFF;
        step(lui_op(5'd1, 20'h12345), 5'd1, a);
        step(imm_op(3'b000, 5'd2, 5'd0, 12'd100), 5'd2, b);
        step(imm_op(3'b000, 5'd3, 5'd0, 12'hFF9), 5'd3, c);
        step(imm_op(3'b110, 5'd4, 5'd2, 12'h0F0), 5'd4, d);
        step(imm_op(3'b100, 5'd5, 5'd4, 12'hFFF), 5'd5, e);
        step(imm_op(3'b111, 5'd6, 5'd5, 12'h0FF), 5'd6, e & 32'h0000_00FF);
        step(reg_op(7'b0000000, 3'b000, 5'd7, 5'd2, 5'd3), 5'd7, b + c);
        step(reg_op(7'b0100000, 3'b000, 5'd8, 5'd3, 5'd2), 5'd8, c - b);
        // Signed compare, -7 is less than 100
        step(reg_op(7'b0000000, 3'b010, 5'd9, 5'd3, 5'd2), 5'd9, 32'd1);
        step(reg_op(7'b0000000, 3'b010, 5'd10, 5'd2, 5'd3), 5'd10, 32'd0);
        step(reg_op(7'b0000000, 3'b110, 5'd11, 5'd1, 5'd2), 5'd11, a | b);
        step(reg_op(7'b0000000, 3'b100, 5'd12, 5'd5, 5'd2), 5'd12, e ^ b);
        step(reg_op(7'b0000000, 3'b111, 5'd13, 5'd5, 5'd4), 5'd13, e & d);
        prog.push_back(ebreak_word);
        run_program("alu");
    endtask

    task automatic memory_test();
        word_t       r;
        word_t       upper;
        logic [19:0] hi;
        logic [11:0] lo;
        r  = $urandom();
        lo = r[11:0];
        // ADDI sign-extends, so the upper part absorbs bit 11
        hi = r[31:12] + 20'(r[11]);
        upper = {hi, 12'd0};
        step(lui_op(5'd1, hi), 5'd1, upper);
        step(imm_op(3'b000, 5'd1, 5'd1, lo), 5'd1, upper + {{20{lo[11]}}, lo});
        step(imm_op(3'b000, 5'd2, 5'd0, 12'h040), 5'd2, 32'h0000_0040);
        step(sw_op(5'd1, 5'd2, 12'd8), 5'd0, 32'd0);
        step(lw_op(5'd3, 5'd2, 12'd8), 5'd3, upper + {{20{lo[11]}}, lo});
        prog.push_back(ebreak_word);
        run_program("memory");
    endtask

    task automatic branch_test();
        step(imm_op(3'b000, 5'd1, 5'd0, 12'd5), 5'd1, 32'd5);
        step(imm_op(3'b000, 5'd2, 5'd0, 12'd5), 5'd2, 32'd5);
        step(branch_op(3'b000, 5'd1, 5'd2, 13'd8), 5'd0, 32'd0);
        prog.push_back(imm_op(3'b000, 5'd3, 5'd0, 12'd1));
        step(branch_op(3'b001, 5'd1, 5'd2, 13'd8), 5'd0, 32'd0);
        step(branch_op(3'b001, 5'd1, 5'd0, 13'd8), 5'd0, 32'd0);
        prog.push_back(imm_op(3'b000, 5'd3, 5'd0, 12'd2));
        step(branch_op(3'b000, 5'd1, 5'd0, 13'd8), 5'd0, 32'd0);
        // Link is pc 32 plus 4
        step(jal_op(5'd4, 21'd8), 5'd4, 32'd32 + 32'd4);
        prog.push_back(imm_op(3'b000, 5'd3, 5'd0, 12'd3));
        prog.push_back(ebreak_word);
        run_program("branch");
    endtask

    task automatic zero_reg_test();
        step(imm_op(3'b000, 5'd0, 5'd0, 12'd55), 5'd0, 32'd0);
        step(lui_op(5'd0, 20'hABCDE), 5'd0, 32'd0);
        step(reg_op(7'b0000000, 3'b000, 5'd5, 5'd0, 5'd0), 5'd5, 32'd0);
        step(imm_op(3'b110, 5'd6, 5'd0, 12'h123), 5'd6, 32'h0000_0123);
        prog.push_back(ebreak_word);
        run_program("x0");
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        arst_n    = 1'b0;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(32'heeb8ee0b));
        repeat (3) @(posedge clock);
        #1;
        arst_n = 1'b1;

        reset_state_test();
        alu_test();
        memory_test();
        branch_test();
        zero_reg_test();

        total_errors = errors + i_dut.u_core.i_checker.failures;
        $display("Checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, i_dut.u_core.i_checker.failures);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- test/cpu_checker.sv
module cpu_checker import cpu_pkg::*; (
    input logic clock,
    input logic arst_n,
    input logic retire_valid,
    input logic halted,
    input pc_t  retire_pc,
    input logic dmem_cen,
    input logic dmem_wen
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions
    int failures = 0;

    // One writeback cycle per instruction
    single_retire: assert property (@(posedge clock) disable iff (!arst_n)
        retire_valid |=> !retire_valid)
    else begin
        $error("retire_valid stayed high for more than one cycle");
        failures++;
    end

    no_retire_when_halted: assert property (@(posedge clock) disable iff (!arst_n)
        !(retire_valid && halted))
    else begin
        $error("retire_valid is high while the core is halted");
        failures++;
    end

    aligned_retire_pc: assert property (@(posedge clock) disable iff (!arst_n)
        retire_valid |-> (retire_pc[1:0] == 2'b00))
    else begin
        $error("retired PC is not word aligned");
        failures++;
    end

    // A data RAM write needs the chip enable as well
    wen_needs_cen: assert property (@(posedge clock) disable iff (!arst_n)
        !dmem_wen |-> !dmem_cen)
    else begin
        $error("dmem_wen is low while dmem_cen is high");
        failures++;
    end

endmodule

bind cpu_core cpu_checker i_checker (
    .clock        (clock),
    .arst_n       (arst_n),
    .retire_valid (retire_valid),
    .halted       (halted),
    .retire_pc    (retire_pc),
    .dmem_cen     (dmem_cen),
    .dmem_wen     (dmem_wen)
);

//--- verilog/cpu_top.sv
`include "cpu_settings.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    run,
    input  logic                    load_en,
    input  logic [`CPU_IMEM_AW-1:0] load_addr,
    input  word_t                   load_data,
    output logic                    retire_valid,
    output pc_t                     retire_pc,
    output reg_idx_t                retire_rd,
    output word_t                   retire_value,
    output logic                    halted
);

    logic                    core_imem_cen, dmem_cen, dmem_wen;
    logic [`CPU_IMEM_AW-1:0] core_imem_addr;
    logic [`CPU_DMEM_AW-1:0] dmem_addr;
    word_t                   imem_rdata, dmem_rdata, dmem_wdata;

    cpu_core u_core (.clock(clock), .arst_n(arst_n), .run(run),
        .imem_cen(core_imem_cen), .imem_addr(core_imem_addr), .imem_rdata(imem_rdata),
        .dmem_cen(dmem_cen), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
        .retire_valid(retire_valid), .halted(halted), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_value(retire_value));

    // Program load owns the instruction RAM while run is low
    cpu_sram #(.aw(`CPU_IMEM_AW)) i_imem (
        .clock (clock),
        .cen   (run ? core_imem_cen : !load_en),
        .wen   (run | !load_en),
        .addr  (run ? core_imem_addr : load_addr),
        .wdata (load_data),
        .rdata (imem_rdata)
    );

    cpu_sram #(.aw(`CPU_DMEM_AW)) i_dmem (
        .clock (clock),
        .cen   (dmem_cen),
        .wen   (dmem_wen),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

endmodule

//--- verilog/cpu_sram.sv
`include "cpu_settings.svh"

module cpu_sram import cpu_pkg::*; #(
    parameter int aw = `CPU_IMEM_AW
) (
    input  logic          clock,
    input  logic          cen,
    input  logic          wen,
    input  logic [aw-1:0] addr,
    input  word_t         wdata,
    output word_t         rdata
);

    word_t mem [2**aw];

    // Write when both enables are low, read when only cen is low
    always_ff @(posedge clock) begin
        if (!cen) begin
            if (!wen) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    // rdata holds its last read until the next one

endmodule

//--- verilog/cpu_core.sv
`include "cpu_settings.svh"

module cpu_core import cpu_pkg::*; (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    run,
    output logic                    imem_cen,
    output logic [`CPU_IMEM_AW-1:0] imem_addr,
    input  word_t                   imem_rdata,
    output logic                    dmem_cen,
    output logic                    dmem_wen,
    output logic [`CPU_DMEM_AW-1:0] dmem_addr,
    output word_t                   dmem_wdata,
    input  word_t                   dmem_rdata,
    output logic                    retire_valid,
    output logic                    halted,
    output pc_t                     retire_pc,
    output reg_idx_t                retire_rd,
    output word_t                   retire_value
);

    core_state_e state, state_nxt;
    pc_t         pc, next_pc, npc_q;
    word_t       instr, instr_q, alu_result, alu_q, rs1_data, rs2_data, imm, wb_value;
    reg_idx_t    rs1, rs2, rd;
    alu_op_e     alu_op;
    logic        reg_write, mem_read, mem_write, is_branch, branch_ne, is_jal;
    logic        use_imm, is_halt;

    // RAM output is only valid in the cycle after fetch
    assign instr = (state == st_execute) ? imem_rdata : instr_q;

    cpu_decode u_decode (.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .alu_op(alu_op), .reg_write(reg_write), .mem_read(mem_read),
        .mem_write(mem_write), .is_branch(is_branch), .branch_ne(branch_ne),
        .is_jal(is_jal), .use_imm(use_imm), .is_halt(is_halt));

    cpu_execute u_execute (.pc(pc), .op_a(rs1_data), .op_b(rs2_data), .imm(imm),
        .alu_op(alu_op), .use_imm(use_imm), .is_branch(is_branch),
        .branch_ne(branch_ne), .is_jal(is_jal), .alu_result(alu_result),
        .next_pc(next_pc));

    cpu_result u_result (.clock(clock), .arst_n(arst_n), .rs1(rs1), .rs2(rs2), .rd(rd),
        .wb_en((state == st_writeback) && reg_write), .wb_load(mem_read),
        .alu_result(alu_q), .load_data(dmem_rdata), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .wb_value(wb_value));

    //////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:      if (run) state_nxt = st_fetch;
            st_fetch:     state_nxt = st_execute;
            st_execute: begin
                if (is_halt)                     state_nxt = st_halted;
                else if (mem_read || mem_write)  state_nxt = st_memory;
                else                             state_nxt = st_writeback;
            end
            st_memory:    state_nxt = st_writeback;
            st_writeback: state_nxt = st_fetch;
            // Dropping run clears the halt for the next program
            st_halted:    if (!run) state_nxt = st_idle;
            default:      state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            pc    <= `CPU_RESET_PC;
        end else begin
            state <= state_nxt;
            if (state == st_writeback) pc <= npc_q;
            else if (state == st_halted && !run) pc <= `CPU_RESET_PC;
        end
    end

    // Instruction, ALU value and target held past execute
    always_ff @(posedge clock) begin
        if (state == st_execute) begin
            instr_q <= imem_rdata;
            alu_q   <= alu_result;
            npc_q   <= next_pc;
        end
    end

    // RAM strobes, all active low
    assign imem_cen   = !(state == st_fetch);
    assign imem_addr  = pc[`CPU_IMEM_AW+1:2];
    assign dmem_cen   = !(state == st_memory);
    assign dmem_wen   = !((state == st_memory) && mem_write);
    assign dmem_addr  = alu_q[`CPU_DMEM_AW+1:2];
    assign dmem_wdata = rs2_data;

    // Stores and branches retire with rd and value 0
    assign retire_valid = (state == st_writeback);
    assign retire_pc    = pc;
    assign retire_rd    = reg_write ? rd : '0;
    assign retire_value = (reg_write && (rd != '0)) ? wb_value : '0;
    assign halted       = (state == st_halted);

endmodule

//--- verilog/cpu_result.sv
module cpu_result import cpu_pkg::*; (
    input  logic     clock,
    input  logic     arst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     wb_en,
    input  logic     wb_load,
    input  word_t    alu_result,
    input  word_t    load_data,
    output word_t    rs1_data,
    output word_t    rs2_data,
    output word_t    wb_value
);

    // x1..x31, x0 has no storage
    word_t regs [1:31];

    // Load data or the latched ALU/link value
    assign wb_value = wb_load ? load_data : alu_result;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (rd != '0)) begin
            regs[rd] <= wb_value;
        end
    end

    // Combinational read ports
    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

//--- verilog/cpu_execute.sv
module cpu_execute import cpu_pkg::*; (
    input  pc_t     pc,
    input  word_t   op_a,
    input  word_t   op_b,
    input  word_t   imm,
    input  alu_op_e alu_op,
    input  logic    use_imm,
    input  logic    is_branch,
    input  logic    branch_ne,
    input  logic    is_jal,
    output word_t   alu_result,
    output pc_t     next_pc
);

    word_t alu_b;
    word_t alu_out;
    pc_t   pc_plus4;
    pc_t   pc_target;
    logic  operands_eq;
    logic  branch_taken;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    assign alu_b = use_imm ? imm : op_b;

    always_comb begin
        case (alu_op)
            alu_add:    alu_out = op_a + alu_b;
            alu_sub:    alu_out = op_a - alu_b;
            alu_and:    alu_out = op_a & alu_b;
            alu_or:     alu_out = op_a | alu_b;
            alu_xor:    alu_out = op_a ^ alu_b;
            // Signed compare
            alu_slt:    alu_out = ($signed(op_a) < $signed(alu_b)) ? word_t'(1) : '0;
            alu_pass_b: alu_out = alu_b;
            default:    alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Branch and next PC
    //////////////////////////////////////////////////

    assign pc_plus4    = pc + 32'd4;
    assign pc_target   = pc + imm;
    assign operands_eq = (op_a == op_b);

    // BNE inverts the equality test
    assign branch_taken = is_branch && (operands_eq ^ branch_ne);

    assign next_pc = (branch_taken || is_jal) ? pc_target : pc_plus4;

    // JAL writes its link address in place of an ALU value
    assign alu_result = is_jal ? pc_plus4 : alu_out;

endmodule

//--- verilog/cpu_decode.sv
module cpu_decode import cpu_pkg::*; (
    input  word_t    instr,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm,
    output alu_op_e  alu_op,
    output logic     reg_write,
    output logic     mem_read,
    output logic     mem_write,
    output logic     is_branch,
    output logic     branch_ne,
    output logic     is_jal,
    output logic     use_imm,
    output logic     is_halt
);

    // Major opcodes of the supported subset
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam word_t      ebreak    = 32'h0010_0073;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Register fields sit at fixed positions in every format
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        // Anything unrecognized falls through as a no-op
        imm       = '0;
        alu_op    = alu_add;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jal    = 1'b0;
        use_imm   = 1'b0;
        is_halt   = 1'b0;
        case (opcode)
            op_lui: begin
                imm       = {instr[31:12], 12'b0};
                alu_op    = alu_pass_b;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            op_imm: begin
                imm     = {{20{instr[31]}}, instr[31:20]};
                use_imm = 1'b1;
                case (funct3)
                    3'b000: begin alu_op = alu_add; reg_write = 1'b1; end
                    3'b100: begin alu_op = alu_xor; reg_write = 1'b1; end
                    3'b110: begin alu_op = alu_or;  reg_write = 1'b1; end
                    3'b111: begin alu_op = alu_and; reg_write = 1'b1; end
                    default: ;
                endcase
            end
            op_reg: begin
                case ({funct7, funct3})
                    10'b0000000_000: begin alu_op = alu_add; reg_write = 1'b1; end
                    10'b0100000_000: begin alu_op = alu_sub; reg_write = 1'b1; end
                    10'b0000000_111: begin alu_op = alu_and; reg_write = 1'b1; end
                    10'b0000000_110: begin alu_op = alu_or;  reg_write = 1'b1; end
                    10'b0000000_100: begin alu_op = alu_xor; reg_write = 1'b1; end
                    10'b0000000_010: begin alu_op = alu_slt; reg_write = 1'b1; end
                    default: ;
                endcase
            end
            op_load: begin
                imm     = {{20{instr[31]}}, instr[31:20]};
                use_imm = 1'b1;
                // Word accesses only
                if (funct3 == 3'b010) begin
                    mem_read  = 1'b1;
                    reg_write = 1'b1;
                end
            end
            op_store: begin
                imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_imm   = 1'b1;
                mem_write = (funct3 == 3'b010);
            end
            op_branch: begin
                imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                             instr[11:8], 1'b0};
                is_branch = (funct3 == 3'b000) || (funct3 == 3'b001);
                branch_ne = (funct3 == 3'b001);
            end
            op_jal: begin
                imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                             instr[30:21], 1'b0};
                is_jal    = 1'b1;
                reg_write = 1'b1;
            end
            default: begin
                is_halt = (instr == ebreak);
            end
        endcase
    end

endmodule

//--- verilog/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    //////////////////////////////////////////////////
    // Widths with a meaning
    //////////////////////////////////////////////////

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [4:0]           reg_idx_t;
    typedef logic [31:0]          pc_t;

    //////////////////////////////////////////////////
    // ALU operations
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        // LUI passes the immediate straight through
        alu_pass_b
    } alu_op_e;

    //////////////////////////////////////////////////
    // Core sequencing
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_execute,
        st_memory,
        st_writeback,
        st_halted
    } core_state_e;

endpackage

//--- verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and instruction word width
`define CPU_XLEN 32

// RAM depths as word address widths
`define CPU_IMEM_AW 6
`define CPU_DMEM_AW 6

// First fetch address after reset or after a halt is cleared
`define CPU_RESET_PC 32'h0000_0000

`endif
